// ==== src/sysmul_config.svh ====
//------------------------------------------------
// systolic multiplier configuration
// operand width and the derived cycle counts
//------------------------------------------------

`ifndef SYSMUL_CONFIG_SVH
`define SYSMUL_CONFIG_SVH

// operand width N in bits, any value from 2 up
`define SYSMUL_DATA_WIDTH 8

// an N by N product takes 2N serial steps
// one product bit leaves the array per step
`define SYSMUL_CYCLE_END (2 * `SYSMUL_DATA_WIDTH)

// counter must be able to reach SYSMUL_CYCLE_END itself
// so size it for CYCLE_END + 1 distinct values
`define SYSMUL_COUNT_WIDTH $clog2(`SYSMUL_CYCLE_END + 1)

`endif

// ==== src/sysmul_pkg.sv ====
//------------------------------------------------
// systolic multiplier types
// operand, product, counter, FSM state and the
// operand pair carried on the top level port
//------------------------------------------------

`default_nettype none

`include "sysmul_config.svh"

package sysmul_pkg;

	// one unsigned operand, N bits
	typedef logic [`SYSMUL_DATA_WIDTH-1:0] operand_t;

	// full unsigned product, 2N bits
	typedef logic [2*`SYSMUL_DATA_WIDTH-1:0] product_t;

	// calculation cycle counter, sized to hold SYSMUL_CYCLE_END
	typedef logic [`SYSMUL_COUNT_WIDTH-1:0] calc_count_t;

	// both operands of one multiplication
	// multiplicand goes serial, multiplier stays parallel in the array
	typedef struct packed {
		operand_t multiplicand;
		operand_t multiplier;
	} operand_pair_t;

	// control FSM states
	// idle waits for begin, load fires the load strobe,
	// calc counts out the serial steps, done flags the result
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		LOAD = 2'd1,
		CALC = 2'd2,
		DONE = 2'd3
	} sysmul_state_t;

endpackage

`default_nettype wire

// ==== src/systolic_multiplier_fsm.sv ====
//------------------------------------------------
// systolic multiplier control FSM
// issues the load strobe, counts the 2N serial
// steps and pulses result ready once per product
//------------------------------------------------

`default_nettype none

`include "sysmul_config.svh"

module systolic_multiplier_fsm (
	input  wire  i_CLK,
	input  wire  i_RESET,
	input  wire  i_clk_enable,
	input  wire  i_begin_mult,
	output logic o_shift_reg_load,
	output logic o_result_ready
);

	import sysmul_pkg::*;

	sysmul_state_t r_current_state;
	sysmul_state_t r_next_state;

	// counts calc cycles, cleared in every other state
	calc_count_t r_calc_counter;

	// next state logic
	always_comb
	begin
		// default is to stay put
		r_next_state = r_current_state;
		case (r_current_state)
			IDLE:
			begin
				// begin is only looked at here
				if (i_begin_mult)
					r_next_state = LOAD;
			end
			LOAD:
			begin
				r_next_state = CALC;
			end
			CALC:
			begin
				// leave once the counter has run the full 2N steps
				if (r_calc_counter == calc_count_t'(`SYSMUL_CYCLE_END))
					r_next_state = DONE;
			end
			DONE:
			begin
				r_next_state = IDLE;
			end
			default:
			begin
				r_next_state = IDLE;
			end
		endcase
	end

	// state register, frozen while the enable is low
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			r_current_state <= IDLE;
		else if (i_clk_enable)
			r_current_state <= r_next_state;
	end

	// calc counter
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			r_calc_counter <= '0;
		else if (i_clk_enable)
		begin
			if (r_current_state == CALC)
				r_calc_counter <= calc_count_t'(r_calc_counter + 1'b1);
			else
				r_calc_counter <= '0;
		end
	end

	// strobes are registered from the state, one enabled cycle late
	// load is seen by the datapath on the edge after LOAD is left
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			o_shift_reg_load <= 1'b0;
			o_result_ready <= 1'b0;
		end
		else if (i_clk_enable)
		begin
			o_shift_reg_load <= (r_current_state == LOAD);
			o_result_ready <= (r_current_state == DONE);
		end
	end

	// ready may only rise on the edge that leaves DONE
	a_ready_after_done: assert property (
		@(posedge i_CLK) disable iff (i_RESET)
		$rose(o_result_ready) |-> ($past(r_current_state) == DONE)
	);

	// load strobe drops on the very next enabled edge
	a_load_one_cycle: assert property (
		@(posedge i_CLK) disable iff (i_RESET)
		(o_shift_reg_load && i_clk_enable) |=> !o_shift_reg_load
	);

	// the two strobes never overlap
	a_strobes_exclusive: assert property (
		@(posedge i_CLK) disable iff (i_RESET)
		!(o_shift_reg_load && o_result_ready)
	);

endmodule

`default_nettype wire

// ==== src/multiplicand_shift_reg.sv ====
//------------------------------------------------
// multiplicand shift register
// parallel load, serial out LSB first, zero fill
//------------------------------------------------

`default_nettype none

`include "sysmul_config.svh"

module multiplicand_shift_reg (
	input  wire                  i_CLK,
	input  wire                  i_RESET,
	input  wire                  i_clk_enable,
	input  wire                  i_load,
	input  wire sysmul_pkg::operand_t i_multiplicand,
	output logic                 o_serial_bit
);

	import sysmul_pkg::*;

	operand_t r_shift;

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			r_shift <= '0;
		else if (i_clk_enable)
		begin
			if (i_load)
				r_shift <= i_multiplicand;
			else
				// zeros behind the operand feed the upper N product steps
				r_shift <= r_shift >> 1;
		end
	end

	// bit 0 is the multiplicand bit for the current step
	assign o_serial_bit = r_shift[0];

	// after N enabled shifts the whole operand has left the register
	a_drained_after_n: assert property (
		@(posedge i_CLK) disable iff (i_RESET)
		(i_load && i_clk_enable) |=>
			i_clk_enable [-> `SYSMUL_DATA_WIDTH] ##1 (r_shift == '0)
	);

endmodule

`default_nettype wire

// ==== src/systolic_cell_array.sv ====
//------------------------------------------------
// systolic multiply-accumulate cell array
// holds the multiplier, takes the multiplicand one
// bit per step and emits one product bit per step
//------------------------------------------------

`default_nettype none

`include "sysmul_config.svh"

module systolic_cell_array (
	input  wire                  i_CLK,
	input  wire                  i_RESET,
	input  wire                  i_clk_enable,
	input  wire                  i_load,
	input  wire sysmul_pkg::operand_t i_multiplier,
	input  wire                  i_serial_bit,
	output logic                 o_product_bit
);

	import sysmul_pkg::*;

	// multiplier bit held by each cell
	operand_t r_multiplier;

	// registered sum and carry of each cell
	operand_t r_sum;
	operand_t r_carry;

	// partial sum arriving at each cell from its upper neighbour
	operand_t w_sum_in;

	// combinational cell results
	operand_t w_sum_next;
	operand_t w_carry_next;

	// sums move down one cell per step as the accumulator shifts right
	// the top cell sees zero
	assign w_sum_in = r_sum >> 1;

	// one multiply-accumulate cell per multiplier bit
	for (genvar i = 0; i < `SYSMUL_DATA_WIDTH; i++)
	begin : g_cell
		// partial product of this cell
		logic w_pp;

		assign w_pp = r_multiplier[i] & i_serial_bit;

		// full add of partial product, incoming sum and own carry
		// carry stays in the cell since it has the same weight after the shift
		assign {w_carry_next[i], w_sum_next[i]} =
			2'(w_pp) + 2'(w_sum_in[i]) + 2'(r_carry[i]);
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			r_multiplier <= '0;
			r_sum <= '0;
			r_carry <= '0;
		end
		else if (i_clk_enable)
		begin
			if (i_load)
			begin
				// new product starts from an empty accumulator
				r_multiplier <= i_multiplier;
				r_sum <= '0;
				r_carry <= '0;
			end
			else
			begin
				r_sum <= w_sum_next;
				r_carry <= w_carry_next;
			end
		end
	end

	// cell 0 holds the LSB of what is left and so the next product bit
	assign o_product_bit = r_sum[0];

	// with the zero-filled multiplicand the accumulator is empty
	// one step after the last of the 2N product bits sat in cell 0
	a_empty_after_product: assert property (
		@(posedge i_CLK) disable iff (i_RESET)
		(i_load && i_clk_enable) |=>
			i_clk_enable [-> `SYSMUL_CYCLE_END + 1] ##1 (r_sum == '0 && r_carry == '0)
	);

endmodule

`default_nettype wire

// ==== src/product_deserializer.sv ====
//------------------------------------------------
// product deserializer
// shifts serial product bits into a 2N-bit window
//------------------------------------------------

`default_nettype none

module product_deserializer (
	input  wire                    i_CLK,
	input  wire                    i_RESET,
	input  wire                    i_clk_enable,
	input  wire                    i_product_bit,
	output sysmul_pkg::product_t   o_product
);

	import sysmul_pkg::*;

	// bits enter at the top and walk down,
	// after 2N shifts bit 0 of the product sits at the bottom
	product_t r_window;

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			r_window <= '0;
		else if (i_clk_enable)
			// free running, only valid while result ready is high
			r_window <= {i_product_bit, r_window[$bits(product_t)-1:1]};
	end

	assign o_product = r_window;

endmodule

`default_nettype wire

// ==== src/systolic_multiplier_top.sv ====
//------------------------------------------------
// bit-serial systolic multiplier top level
// connects the control FSM to the serial datapath
//------------------------------------------------

`default_nettype none

module systolic_multiplier_top (
	input  wire                        i_CLK,
	input  wire                        i_RESET,
	input  wire                        i_clk_enable,
	input  wire                        i_begin_mult,
	input  wire sysmul_pkg::operand_pair_t i_operands,
	output sysmul_pkg::product_t       o_product,
	output logic                       o_result_ready
);

	// load strobe to shift register and array
	logic w_shift_reg_load;

	// multiplicand bit into the array
	logic w_serial_bit;

	// product bit out of the array
	logic w_product_bit;

	systolic_multiplier_fsm u_fsm (
		.i_CLK            (i_CLK),
		.i_RESET          (i_RESET),
		.i_clk_enable     (i_clk_enable),
		.i_begin_mult     (i_begin_mult),
		.o_shift_reg_load (w_shift_reg_load),
		.o_result_ready   (o_result_ready)
	);

	// multiplicand half of the operand pair goes serial
	multiplicand_shift_reg u_shift_reg (
		.i_CLK          (i_CLK),
		.i_RESET        (i_RESET),
		.i_clk_enable   (i_clk_enable),
		.i_load         (w_shift_reg_load),
		.i_multiplicand (i_operands.multiplicand),
		.o_serial_bit   (w_serial_bit)
	);

	// multiplier half is held inside the cells
	systolic_cell_array u_cell_array (
		.i_CLK         (i_CLK),
		.i_RESET       (i_RESET),
		.i_clk_enable  (i_clk_enable),
		.i_load        (w_shift_reg_load),
		.i_multiplier  (i_operands.multiplier),
		.i_serial_bit  (w_serial_bit),
		.o_product_bit (w_product_bit)
	);

	product_deserializer u_deserializer (
		.i_CLK         (i_CLK),
		.i_RESET       (i_RESET),
		.i_clk_enable  (i_clk_enable),
		.i_product_bit (w_product_bit),
		.o_product     (o_product)
	);

endmodule

`default_nettype wire

// ==== dv/sysmul_checker.sv ====
//------------------------------------------------
// systolic multiplier checker
// records operands at each accepted begin and
// compares o_product at each result ready pulse
//------------------------------------------------

`default_nettype none

module sysmul_checker (
	input  wire                        i_CLK,
	input  wire                        i_RESET,
	input  wire                        i_clk_enable,
	input  wire                        i_begin_mult,
	input  wire sysmul_pkg::operand_pair_t i_operands,
	input  wire sysmul_pkg::product_t  i_product,
	input  wire                        i_result_ready,
	output int                         o_value_errors,
	output int                         o_protocol_errors,
	output int                         o_results_seen
);

	timeunit 1ns;
	timeprecision 1ps;

	import sysmul_pkg::*;

	// own model of the FSM being away from idle
	logic busy;
	// ready as seen at the previous enabled edge
	logic ready_last;
	operand_pair_t accepted;
	product_t expected;

	// schoolbook sum of shifted multiplicands
	function automatic product_t expected_product(input operand_t multiplicand,
		input operand_t multiplier);
		product_t acc;
		acc = '0;
		for (int i = 0; i < $bits(operand_t); i++)
		begin
			if (multiplier[i])
				acc = acc + (product_t'(multiplicand) << i);
		end
		return acc;
	endfunction

	always @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			busy = 1'b0;
			ready_last = 1'b0;
			o_value_errors = 0;
			o_protocol_errors = 0;
			o_results_seen = 0;
		end
		else if (i_clk_enable)
		begin
			// result first, the FSM is back in idle while ready is high
			if (i_result_ready)
			begin
				if (ready_last)
				begin
					o_protocol_errors++;
					$display("%0t: result ready stayed high for a second enabled cycle", $time);
				end
				else if (!busy)
				begin
					o_protocol_errors++;
					$display("%0t: result ready pulsed with no multiplication accepted", $time);
				end
				else
				begin
					o_results_seen++;
					busy = 1'b0;
					expected = expected_product(accepted.multiplicand, accepted.multiplier);
					if (i_product !== expected)
					begin
						o_value_errors++;
						$display("FAILED time %0t o_product: expected %h, got %h (%h * %h)",
							$time, expected, i_product, accepted.multiplicand,
							accepted.multiplier);
					end
				end
			end
			ready_last = i_result_ready;
			// begin only counts when idle, otherwise the DUT drops it
			if (!busy && i_begin_mult)
			begin
				accepted = i_operands;
				busy = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_systolic_multiplier.sv ====
//------------------------------------------------
// systolic multiplier testbench
// clock, reset, LFSR driven stimulus and timeout
//------------------------------------------------

`default_nettype none

`include "sysmul_config.svh"

module tb_systolic_multiplier;

	timeunit 1ns;
	timeprecision 1ps;

	import sysmul_pkg::*;

	localparam int NUM_CORNER = 6;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_STALL = 100;
	localparam int NUM_NOISY = 30;
	localparam int NUM_TESTS = NUM_CORNER + NUM_RANDOM + NUM_STALL + NUM_NOISY;
	localparam int RESET_CYCLES = 4;
	// 4x margin covers enable stalls and the gaps between tests
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (2 * `SYSMUL_DATA_WIDTH + 4) * 4 + RESET_CYCLES;

	logic i_CLK = 1'b0;
	logic i_RESET = 1'b1;
	logic i_clk_enable = 1'b1;
	logic i_begin_mult = 1'b0;
	operand_pair_t i_operands = '0;
	product_t o_product;
	logic o_result_ready;

	int value_errors;
	int protocol_errors;
	int results_seen;
	int missing;
	int cycle_count = 0;
	logic [31:0] lfsr_state = 32'h92d6_dfbd;
	// when set the enable is redrawn every cycle
	logic stall_enable = 1'b0;

	always #20 i_CLK = ~i_CLK;

	systolic_multiplier_top u_dut (
		.i_CLK          (i_CLK),
		.i_RESET        (i_RESET),
		.i_clk_enable   (i_clk_enable),
		.i_begin_mult   (i_begin_mult),
		.i_operands     (i_operands),
		.o_product      (o_product),
		.o_result_ready (o_result_ready)
	);

	sysmul_checker u_checker (
		.i_CLK             (i_CLK),
		.i_RESET           (i_RESET),
		.i_clk_enable      (i_clk_enable),
		.i_begin_mult      (i_begin_mult),
		.i_operands        (i_operands),
		.i_product         (o_product),
		.i_result_ready    (o_result_ready),
		.o_value_errors    (value_errors),
		.o_protocol_errors (protocol_errors),
		.o_results_seen    (results_seen)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic draw_bit(output logic value);
		lfsr_state = lfsr_next(lfsr_state);
		value = lfsr_state[0];
	endtask

	task automatic draw_operand(output operand_t value);
		for (int i = 0; i < $bits(operand_t); i++)
			draw_bit(value[i]);
	endtask

	task automatic draw_count(input int width, output int value);
		logic b;
		value = 0;
		for (int i = 0; i < width; i++)
		begin
			draw_bit(b);
			value = (value << 1) | int'(b);
		end
	endtask

	// inputs change 2 ns after the rising edge
	task automatic next_cycle();
		int roll;
		@(posedge i_CLK);
		#2;
		if (stall_enable)
		begin
			// low for 3 of 8 values, roughly a third
			draw_count(3, roll);
			i_clk_enable = (roll >= 3);
		end
		else
			i_clk_enable = 1'b1;
	endtask

	// one multiplication, optionally with stray begins while busy
	task automatic run_product(input operand_t multiplicand, input operand_t multiplier,
		input logic noisy);
		logic en_was;
		logic noise;
		i_operands.multiplicand = multiplicand;
		i_operands.multiplier = multiplier;
		i_begin_mult = 1'b1;
		// hold begin until an enabled edge has seen it
		do
		begin
			en_was = i_clk_enable;
			next_cycle();
		end while (!en_was);
		i_begin_mult = 1'b0;
		while (!o_result_ready)
		begin
			next_cycle();
			if (noisy)
			begin
				draw_bit(noise);
				i_begin_mult = noise;
			end
		end
		i_begin_mult = 1'b0;
	endtask

	task automatic random_products(input int count, input logic noisy);
		operand_t a;
		operand_t b;
		int gap;
		for (int n = 0; n < count; n++)
		begin
			draw_operand(a);
			draw_operand(b);
			run_product(a, b, noisy);
			draw_count(2, gap);
			repeat (gap) next_cycle();
		end
	endtask

	always @(posedge i_CLK)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, result ready never came for %0d of %0d",
				cycle_count, NUM_TESTS - results_seen, NUM_TESTS);
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		repeat (RESET_CYCLES) @(posedge i_CLK);
		#2;
		i_RESET = 1'b0;
		// idle, the checker flags any ready here
		repeat (20) next_cycle();
		run_product('0, '0, 1'b0);
		run_product('0, '1, 1'b0);
		run_product(1, '1, 1'b0);
		run_product('1, '1, 1'b0);
		run_product('1, 1, 1'b0);
		run_product(1, 1, 1'b0);
		random_products(NUM_RANDOM, 1'b0);
		stall_enable = 1'b1;
		random_products(NUM_STALL, 1'b0);
		random_products(NUM_NOISY, 1'b1);
		stall_enable = 1'b0;
		// let the checker take the last ready pulse
		repeat (4) next_cycle();
		missing = (results_seen < NUM_TESTS) ? NUM_TESTS - results_seen : 0;
		if (missing != 0)
			$display("%0d of %0d multiplications never gave result ready", missing, NUM_TESTS);
		$display("value errors %0d, protocol errors %0d, missing results %0d",
			value_errors, protocol_errors, missing);
		if (value_errors == 0 && protocol_errors == 0 && missing == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/sysmul_pkg.sv
src/systolic_multiplier_fsm.sv
src/multiplicand_shift_reg.sv
src/systolic_cell_array.sv
src/product_deserializer.sv
src/systolic_multiplier_top.sv
dv/sysmul_checker.sv
dv/tb_systolic_multiplier.sv

// ==== Bender.yml ====
package:
  name: systolic_multiplier

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/sysmul_pkg.sv
      - src/systolic_multiplier_fsm.sv
      - src/multiplicand_shift_reg.sv
      - src/systolic_cell_array.sv
      - src/product_deserializer.sv
      - src/systolic_multiplier_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/sysmul_checker.sv
      - dv/tb_systolic_multiplier.sv
